//--- verilog.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/pipeReg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/memArbiter.sv
verilog/cpuTop.sv
dv/cpuTb.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module cpuTb -f verilog.f -o VcpuTb \
   && ./obj_dir/VcpuTb | grep "ALL TESTS PASSED" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- dv/program.hex
// One 16-bit instruction word per line, word address 0 upward
// Format op[15:11] rs[10:8] rt[7:5] imm5 or rd[4:2] func[1:0]
4025
415D
D94C
4B81
54BF
5DCF
D95D
DDC6
DCEB
937F
93FF
EB94
F478
E13C
FB94
CB18
6004
40E1
40E2
6804
7402
40E3
7C02
7B02
40E4
2002
40E5
40A0
9580
85C2
8D22
4141
2DC8
40E6
40E7
40E8
42E2
0000
4029

//--- dv/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTb import isaPkg::*; ();

   localparam int resetCycles = 16;
   localparam int progWords   = 39;
   localparam int loopCount   = 1;
   // Budget of 8 cycles per program word plus reset
   localparam int limitCycles = resetCycles + 8 * progWords * loopCount;

   logic                clk;
   logic                rstN;
   logic                wbValid;
   logic [regAddrW-1:0] wbReg;
   logic [wordW-1:0]    wbData;
   logic                halted;

   // Instruction-level model state and expected retire stream
   logic [wordW-1:0]    modelMem [memDepth];
   logic [wordW-1:0]    modelRegs [2**regAddrW];
   logic [regAddrW-1:0] expReg [$];
   logic [wordW-1:0]    expData [$];
   int                  retired;
   int                  errors;

   cpuTop i_cpuTop (.clk, .rstN, .wbValid, .wbReg, .wbData, .halted);

   always #2 clk = ~clk;

   // Sign extend the low bits of v
   function automatic logic [wordW-1:0] signExt(input logic [wordW-1:0] v, input int bits);
      logic [wordW-1:0] upper;
      upper = '1 << bits;
      return v[bits-1] ? (v | upper) : (v & ~upper);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Sequential reference, one instruction per step, no pipeline
   //////////////////////////////////////////////////////////////////////
   task automatic runModel();
      logic [wordW-1:0]    pc, ins, a, b, r, imm5, imm8, ad;
      logic [wordW:0]      wide;
      logic [4:0]          op;
      logic [regAddrW-1:0] rs, rt, rd, dst;
      logic                wr, done;
      int                  steps;
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         ins  = modelMem[pc[8:1]];
         op   = ins[15:11];
         rs   = ins[10:8];
         rt   = ins[7:5];
         rd   = ins[4:2];
         a    = modelRegs[rs];
         b    = modelRegs[rt];
         imm5 = signExt(ins, 5);
         imm8 = signExt(ins, 8);
         ad   = a + imm5;
         pc   = pc + 16'd2;
         wr   = 1'b1;
         dst  = rt;
         r    = '0;
         case (op)
            opHalt: begin
               done = 1'b1;
               wr   = 1'b0;
            end
            opAddi:  r = a + imm5;
            opSubi:  r = imm5 - a;
            opXori:  r = a ^ {11'b0, ins[4:0]};
            opAndni: r = a & ~{11'b0, ins[4:0]};
            // Branch offsets are relative to the next PC
            opBeqz: begin
               wr = 1'b0;
               if (a == 0) pc = pc + imm8;
            end
            opBnez: begin
               wr = 1'b0;
               if (a != 0) pc = pc + imm8;
            end
            opBltz: begin
               wr = 1'b0;
               if (a[15]) pc = pc + imm8;
            end
            opBgez: begin
               wr = 1'b0;
               if (!a[15]) pc = pc + imm8;
            end
            opJ: begin
               wr = 1'b0;
               pc = pc + signExt(ins, 11);
            end
            opJr: begin
               wr = 1'b0;
               pc = a + imm8;
            end
            opSt: begin
               wr = 1'b0;
               modelMem[ad[8:1]] = b;
            end
            opLd: r = modelMem[ad[8:1]];
            opSlbi: begin
               dst = rs;
               r   = {a[7:0], ins[7:0]};
            end
            opBtr: begin
               dst = rd;
               for (int i = 0; i < wordW; i++) r[i] = a[wordW-1-i];
            end
            opAluR: begin
               dst = rd;
               case (ins[1:0])
                  2'b00: r = a + b;
                  2'b01: r = b - a;
                  2'b10: r = a ^ b;
                  default: r = a & ~b;
               endcase
            end
            opSeq: begin
               dst = rd;
               r   = {15'b0, a == b};
            end
            opSlt: begin
               dst = rd;
               r   = {15'b0, $signed(a) < $signed(b)};
            end
            opSle: begin
               dst = rd;
               r   = {15'b0, $signed(a) <= $signed(b)};
            end
            opSco: begin
               dst  = rd;
               wide = {1'b0, a} + {1'b0, b};
               r    = {15'b0, wide[wordW]};
            end
            default: wr = 1'b0;
         endcase
         if (wr) begin
            modelRegs[dst] = r;
            expReg.push_back(dst);
            expData.push_back(r);
         end
         steps++;
      end
      if (!done) begin
         $display("Reference model never reached HALT");
         errors++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Retire stream checks, sampled mid-cycle where outputs are stable
   //////////////////////////////////////////////////////////////////////
   always @(negedge clk) begin
      if (rstN && wbValid) begin
         assert (!halted) else begin
            $display("Register write retired after halt at %0t", $time);
            errors++;
         end
         assert (retired < expReg.size()) else begin
            $display("Extra retirement beyond the model stream at %0t", $time);
            errors++;
         end
         if (retired < expReg.size()) begin
            assert (wbReg == expReg[retired] && wbData == expData[retired]) else begin
               $display("mismatch at %0t: write %0d got r%0d=%h, expected r%0d=%h",
                        $time, retired, wbReg, wbData, expReg[retired], expData[retired]);
               errors++;
            end
         end
         retired++;
      end
   end

   initial begin
      clk     = 1'b0;
      rstN    = 1'b0;
      retired = 0;
      errors  = 0;
      $readmemh("dv/program.hex", modelMem);
      for (int i = 0; i < 2**regAddrW; i++) modelRegs[i] = '0;
      runModel();
      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;
      while (!halted) @(posedge clk);
      // Linger to catch any late retirement
      repeat (20) @(posedge clk);
      assert (retired == expReg.size()) else begin
         $display("Retired %0d writes, model expects %0d", retired, expReg.size());
         errors++;
      end
      $display("Retired writes %0d, errors %0d", retired, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (limitCycles) @(posedge clk);
      $display("Timeout: halted did not rise within %0d cycles", limitCycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop import isaPkg::*, pipePkg::*; (
   input  logic                clk,
   input  logic                rstN,
   output logic                wbValid,
   output logic [regAddrW-1:0] wbReg,
   output logic [wordW-1:0]    wbData,
   output logic                halted
);

   fetchToDecodeT    fetchOut, fdOut;
   decodeToExecT     decodeOut, dxOut;
   execToMemT        execOut, xmOut;
   memToWbT          memOut, wb;
   memReqT           instrReq, dataReq;
   logic             instrGrant, loadUseStall, squash;
   logic [wordW-1:0] newPc, rdata;

   ///////////////////////////////////////////////////////////////////////
   // IF
   ///////////////////////////////////////////////////////////////////////
   // Lost grant is folded in inside fetch
   fetchStage i_fetch (
      .clk, .rstN,
      .stall(loadUseStall | halted),
      .redirect(squash),
      .newPc,
      .instrGrant,
      .instrData(rdata),
      .instrReq,
      .toDecode(fetchOut)
   );

   pipeReg #(.payloadT(fetchToDecodeT)) fdReg (
      .clk, .rstN, .stall(loadUseStall), .flush(squash), .d(fetchOut), .q(fdOut)
   );

   // ID
   decodeStage i_decode (
      .clk, .rstN,
      .fromFetch(fdOut),
      .inExec(dxOut),
      .wb,
      .toExec(decodeOut),
      .loadUseStall,
      .halted
   );

   // Load-use inserts its bubble here
   pipeReg #(.payloadT(decodeToExecT)) dxReg (
      .clk, .rstN, .stall(1'b0), .flush(squash | loadUseStall), .d(decodeOut), .q(dxOut)
   );

   // EX
   executeStage i_execute (
      .fromDecode(dxOut), .inMem(xmOut), .wb, .toMem(execOut), .squash, .newPc
   );

   pipeReg #(.payloadT(execToMemT)) xmReg (
      .clk, .rstN, .stall(1'b0), .flush(1'b0), .d(execOut), .q(xmOut)
   );

   // MEM
   memStage i_mem (.fromExec(xmOut), .memData(rdata), .dataReq, .toWb(memOut));

   pipeReg #(.payloadT(memToWbT)) mwReg (
      .clk, .rstN, .stall(1'b0), .flush(1'b0), .d(memOut), .q(wb)
   );

   memArbiter i_arbiter (.clk, .rstN, .instrReq, .dataReq, .instrGrant, .rdata);

   // Retire port shows register writes only
   assign wbValid = wb.valid & wb.regWrite;
   assign wbReg   = wb.destReg;
   assign wbData  = wb.data;

endmodule

`default_nettype wire

//--- verilog/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter import isaPkg::*, pipePkg::*; (
   input  logic             clk,
   input  logic             rstN,
   input  memReqT           instrReq,
   input  memReqT           dataReq,
   output logic             instrGrant,
   output logic [wordW-1:0] rdata
);

   logic [wordW-1:0]   mem [memDepth];
   logic [wordW-1:0]   addr;
   logic [memIdxW-1:0] idx;

   // Program image, same file the testbench model reads
   initial begin
      $readmemh("dv/program.hex", mem);
   end

   ///////////////////////////////////////////////////////////////////////
   // Fixed priority, data port first
   ///////////////////////////////////////////////////////////////////////
   assign instrGrant = instrReq.req & ~dataReq.req;

   assign addr = dataReq.req ? dataReq.addr : instrReq.addr;
   // Byte address, drop bit 0
   assign idx  = addr[memIdxW:1];

   // Read is combinational for whoever owns the port
   assign rdata = mem[idx];

   // Store lands at the clock edge, blocked while in reset
   always_ff @(posedge clk) begin
      if (rstN && dataReq.req && dataReq.write) begin
         mem[dataReq.addr[memIdxW:1]] <= dataReq.wdata;
      end
   end

endmodule

`default_nettype wire

//--- verilog/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage import isaPkg::*, pipePkg::*; (
   input  execToMemT        fromExec,
   input  logic [wordW-1:0] memData,
   output memReqT           dataReq,
   output memToWbT          toWb
);

   logic access;

   // Any valid load or store takes the memory this cycle
   assign access = fromExec.valid & (fromExec.memRead | fromExec.memWrite);

   assign dataReq.req   = access;
   assign dataReq.write = fromExec.valid & fromExec.memWrite;
   assign dataReq.addr  = fromExec.result;
   assign dataReq.wdata = fromExec.storeData;

   // Loads write back the memory word, everything else the ALU result
   assign toWb.valid    = fromExec.valid;
   assign toWb.destReg  = fromExec.destReg;
   assign toWb.regWrite = fromExec.regWrite;
   assign toWb.data     = fromExec.memRead ? memData : fromExec.result;
   assign toWb.halt     = fromExec.halt;

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import isaPkg::*, pipePkg::*; (
   input  decodeToExecT     fromDecode,
   input  execToMemT        inMem,
   input  memToWbT          wb,
   output execToMemT        toMem,
   output logic             squash,
   output logic [wordW-1:0] newPc
);

   opcodeT           op;
   logic [1:0]       func;
   logic [wordW-1:0] instr;
   logic [wordW-1:0] aVal, rtVal, bVal;
   logic [wordW-1:0] imm5s, imm5z, imm8s, imm11s;
   logic [wordW-1:0] aIn, bIn, sum, result, brTarget;
   logic [wordW:0]   addFull;
   logic             invA, invB, carry, zf, sf, ovf, lt, taken;

   // Priority: MEM stage, then WB, then register file value
   function automatic logic [wordW-1:0] fwdValue(
      input logic [regAddrW-1:0] src,
      input logic [wordW-1:0]    regVal,
      input execToMemT           memSt,
      input memToWbT             wbSt
   );
      if (memSt.valid && memSt.regWrite && memSt.destReg == src) begin
         return memSt.result;
      end
      if (wbSt.valid && wbSt.regWrite && wbSt.destReg == src) begin
         return wbSt.data;
      end
      return regVal;
   endfunction

   assign instr = fromDecode.instr;
   assign op    = opcodeT'(instr[15:11]);
   assign func  = instr[1:0];

   // WB forward also covers the same-cycle register write
   assign aVal  = fwdValue(fromDecode.rs, fromDecode.regA, inMem, wb);
   assign rtVal = fwdValue(fromDecode.rt, fromDecode.regB, inMem, wb);

   ///////////////////////////////////////////////////////////////////////
   // Immediates and B operand
   ///////////////////////////////////////////////////////////////////////
   assign imm5s  = {{(wordW-5){instr[4]}}, instr[4:0]};
   assign imm5z  = {{(wordW-5){1'b0}}, instr[4:0]};
   assign imm8s  = {{(wordW-8){instr[7]}}, instr[7:0]};
   assign imm11s = {{(wordW-11){instr[10]}}, instr[10:0]};

   always_comb begin
      case (op)
         opAddi, opSubi, opLd, opSt: bVal = imm5s;
         // Logic immediates are zero extended
         opXori, opAndni:            bVal = imm5z;
         opJr:                       bVal = imm8s;
         opSlbi:                     bVal = {aVal[7:0], instr[7:0]};
         default:                    bVal = rtVal;
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // ALU adder with operand inversion
   ///////////////////////////////////////////////////////////////////////
   // SUB/SUBI compute B - A
   assign invA = (op == opSubi) | ((op == opAluR) & (func == fnSub));
   // Set-less/equal compare as A - B, SCO keeps a plain add
   assign invB = (op == opSeq) | (op == opSlt) | (op == opSle);

   assign aIn     = invA ? ~aVal : aVal;
   assign bIn     = invB ? ~bVal : bVal;
   assign addFull = {1'b0, aIn} + {1'b0, bIn} + {{wordW{1'b0}}, invA | invB};
   assign sum     = addFull[wordW-1:0];
   assign carry   = addFull[wordW];

   // Flags for the set conditions
   assign zf  = (sum == '0);
   assign sf  = sum[wordW-1];
   assign ovf = (aIn[wordW-1] == bIn[wordW-1]) & (sf != aIn[wordW-1]);
   // Sign flips on signed overflow
   assign lt  = sf ^ ovf;

   always_comb begin
      case (op)
         opXori:  result = aVal ^ bVal;
         opAndni: result = aVal & ~bVal;
         opSlbi:  result = bVal;
         opBtr:   result = {<<{aVal}};
         opSeq:   result = {{(wordW-1){1'b0}}, zf};
         opSlt:   result = {{(wordW-1){1'b0}}, lt};
         opSle:   result = {{(wordW-1){1'b0}}, lt | zf};
         opSco:   result = {{(wordW-1){1'b0}}, carry};
         opAluR: begin
            case (func)
               fnXor:   result = aVal ^ bVal;
               fnAndn:  result = aVal & ~bVal;
               default: result = sum;
            endcase
         end
         // Add, sub and load/store address
         default: result = sum;
      endcase
   end

   ///////////////////////////////////////////////////////////////////////
   // Branch resolution
   ///////////////////////////////////////////////////////////////////////
   always_comb begin
      case (op)
         opBeqz:  taken = (aVal == '0);
         opBnez:  taken = (aVal != '0);
         opBltz:  taken = aVal[wordW-1];
         opBgez:  taken = ~aVal[wordW-1];
         // HALT loops on itself so nothing behind it retires
         opJ, opJr, opHalt: taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign brTarget = fromDecode.incrPc + ((op == opJ) ? imm11s : imm8s);

   always_comb begin
      case (op)
         opJr:    newPc = sum;
         opHalt:  newPc = fromDecode.incrPc - pcStep;
         default: newPc = brTarget;
      endcase
   end

   // Kills the two younger instructions in IF/ID and ID/EX
   assign squash = fromDecode.valid & taken;

   assign toMem.valid     = fromDecode.valid;
   assign toMem.result    = result;
   assign toMem.storeData = rtVal;
   assign toMem.destReg   = fromDecode.destReg;
   assign toMem.regWrite  = fromDecode.regWrite;
   assign toMem.memRead   = fromDecode.memRead;
   assign toMem.memWrite  = fromDecode.memWrite;
   assign toMem.halt      = fromDecode.halt;

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
   input  logic          clk,
   input  logic          rstN,
   input  fetchToDecodeT fromFetch,
   input  decodeToExecT  inExec,
   input  memToWbT       wb,
   output decodeToExecT  toExec,
   output logic          loadUseStall,
   output logic          halted
);

   logic [wordW-1:0]    regs [2**regAddrW];
   opcodeT              op;
   logic [regAddrW-1:0] rs, rt, rd, dest;
   logic                rsUsed, rtUsed, regWrite, isLoad, isStore, isHalt;
   logic                wbWrite;

   // Writeback bus carries a register write this cycle
   assign wbWrite = wb.valid & wb.regWrite;

   ///////////////////////////////////////////////////////////////////////
   // Register file, written from the writeback bus
   ///////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 2**regAddrW; i++) begin
            regs[i] <= '0;
         end
      end else if (wbWrite) begin
         regs[wb.destReg] <= wb.data;
      end
   end

   // Sticky once a HALT retires
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         halted <= 1'b0;
      end else if (wb.valid && wb.halt) begin
         halted <= 1'b1;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Field decode
   ///////////////////////////////////////////////////////////////////////
   assign op = opcodeT'(fromFetch.instr[15:11]);
   assign rs = fromFetch.instr[10:8];
   assign rt = fromFetch.instr[7:5];
   assign rd = fromFetch.instr[4:2];

   always_comb begin
      // Most opcodes read rs and target rt
      rsUsed   = 1'b1;
      rtUsed   = 1'b0;
      regWrite = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      isHalt   = 1'b0;
      dest     = rt;
      case (op)
         opHalt: begin
            rsUsed = 1'b0;
            isHalt = 1'b1;
         end
         opNop, opJ: rsUsed = 1'b0;
         opAddi, opSubi, opXori, opAndni: regWrite = 1'b1;
         opLd: begin
            regWrite = 1'b1;
            isLoad   = 1'b1;
         end
         // Store data comes from the rt field
         opSt: begin
            rtUsed  = 1'b1;
            isStore = 1'b1;
         end
         // SLBI rewrites its own source
         opSlbi: begin
            regWrite = 1'b1;
            dest     = rs;
         end
         opBtr: begin
            regWrite = 1'b1;
            dest     = rd;
         end
         opAluR, opSeq, opSlt, opSle, opSco: begin
            rtUsed   = 1'b1;
            regWrite = 1'b1;
            dest     = rd;
         end
         default: ;
      endcase
   end

   // Controls are masked by valid so bubbles do nothing downstream
   assign toExec.valid    = fromFetch.valid;
   assign toExec.instr    = fromFetch.instr;
   assign toExec.incrPc   = fromFetch.incrPc;
   // Write-through read, a writeback landing this cycle is seen here
   assign toExec.regA     = (wbWrite && wb.destReg == rs) ? wb.data : regs[rs];
   assign toExec.regB     = (wbWrite && wb.destReg == rt) ? wb.data : regs[rt];
   assign toExec.rs       = rs;
   assign toExec.rt       = rt;
   assign toExec.destReg  = dest;
   assign toExec.rsUsed   = fromFetch.valid & rsUsed;
   assign toExec.rtUsed   = fromFetch.valid & rtUsed;
   assign toExec.regWrite = fromFetch.valid & regWrite;
   assign toExec.memRead  = fromFetch.valid & isLoad;
   assign toExec.memWrite = fromFetch.valid & isStore;
   assign toExec.halt     = fromFetch.valid & isHalt;

   // Load in EX feeding a source here, wait one cycle
   assign loadUseStall = fromFetch.valid & inExec.valid & inExec.memRead &
                         ((rsUsed & (inExec.destReg == rs)) |
                          (rtUsed & (inExec.destReg == rt)));

endmodule

`default_nettype wire

//--- verilog/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage import isaPkg::*, pipePkg::*; (
   input  logic             clk,
   input  logic             rstN,
   input  logic             stall,
   input  logic             redirect,
   input  logic [wordW-1:0] newPc,
   input  logic             instrGrant,
   input  logic [wordW-1:0] instrData,
   output memReqT           instrReq,
   output fetchToDecodeT    toDecode
);

   logic [wordW-1:0] pc;
   logic             advance;

   // Only step when the memory gave us the word and nobody holds fetch
   assign advance = instrGrant & ~stall;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (redirect) begin
         // Redirect beats any stall
         pc <= newPc;
      end else if (advance) begin
         pc <= pc + pcStep;
      end
   end

   // Read request at PC every cycle, fetch never writes
   assign instrReq.req   = 1'b1;
   assign instrReq.write = 1'b0;
   assign instrReq.addr  = pc;
   assign instrReq.wdata = '0;

   // Lost arbitration or held, send a bubble down
   assign toDecode.valid  = advance;
   assign toDecode.instr  = advance ? instrData : nopInstr;
   assign toDecode.incrPc = pc + pcStep;

endmodule

`default_nettype wire

//--- verilog/pipeReg.sv
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    rstN,
   input  logic    stall,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   // All-zero payload has valid low, so it is a bubble
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         q <= '0;
      end else if (flush) begin
         // Flush wins over stall
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

//--- verilog/pipePkg.sv
`default_nettype none

package pipePkg;
   import isaPkg::*;

   // IF -> ID
   typedef struct packed {
      logic             valid;
      logic [wordW-1:0] instr;
      logic [wordW-1:0] incrPc;
   } fetchToDecodeT;

   // ID -> EX, register values are pre-forwarding
   typedef struct packed {
      logic                valid;
      logic [wordW-1:0]    instr;
      logic [wordW-1:0]    incrPc;
      logic [wordW-1:0]    regA;
      logic [wordW-1:0]    regB;
      logic [regAddrW-1:0] rs;
      logic [regAddrW-1:0] rt;
      logic [regAddrW-1:0] destReg;
      logic                rsUsed;
      logic                rtUsed;
      logic                regWrite;
      logic                memRead;
      logic                memWrite;
      logic                halt;
   } decodeToExecT;

   // EX -> MEM
   typedef struct packed {
      logic                valid;
      logic [wordW-1:0]    result;
      logic [wordW-1:0]    storeData;
      logic [regAddrW-1:0] destReg;
      logic                regWrite;
      logic                memRead;
      logic                memWrite;
      logic                halt;
   } execToMemT;

   // MEM -> WB, also the writeback bus
   typedef struct packed {
      logic                valid;
      logic [regAddrW-1:0] destReg;
      logic                regWrite;
      logic [wordW-1:0]    data;
      logic                halt;
   } memToWbT;

   // One memory port request
   typedef struct packed {
      logic             req;
      logic             write;
      logic [wordW-1:0] addr;
      logic [wordW-1:0] wdata;
   } memReqT;

endpackage

`default_nettype wire

//--- verilog/isaPkg.sv
`default_nettype none

package isaPkg;

   // Datapath and register index widths
   localparam int wordW    = 16;
   localparam int regAddrW = 3;

   // Unified memory, byte addressed, word index from bits 8..1
   localparam int memDepth = 256;
   localparam int memIdxW  = $clog2(memDepth);

   // Sequential PC step in bytes
   localparam logic [wordW-1:0] pcStep = 16'd2;

   // Bubble encoding, opcode 00001
   localparam logic [wordW-1:0] nopInstr = 16'h0800;

   // Kept opcodes, instr[15:11]
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opBtr   = 5'b11001,
      opAluR  = 5'b11011,
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcodeT;

   // R-format function field, instr[1:0]
   localparam logic [1:0] fnAdd  = 2'b00;
   localparam logic [1:0] fnSub  = 2'b01;
   localparam logic [1:0] fnXor  = 2'b10;
   localparam logic [1:0] fnAndn = 2'b11;

endpackage

`default_nettype wire
